//--- verilog/frame_rx_settings.svh
`ifndef FRAME_RX_SETTINGS_SVH
`define FRAME_RX_SETTINGS_SVH

// bytes per frame, sync + opcode + 8 payload + seq + sum
`define FRAME_BYTES 12

// two whole frames of buffering
`define FIFO_DEPTH 32

`define SYNC_BYTE 8'hA5

`define BYTE_W 8

`endif

//--- verilog/frame_types_pkg.sv
`default_nettype none
`include "frame_rx_settings.svh"

package frame_types_pkg;

    // byte 0 sits at bits 0:7, the most significant end
    typedef logic [0:`FRAME_BYTES*`BYTE_W-1] frame_t;

    typedef enum logic [7:0] {
        op_write = 8'h01,
        op_read  = 8'h02,
        op_ping  = 8'h03
    } opcode_e;

    typedef enum logic [1:0] {
        st_ok,
        st_bad_sync,
        st_bad_sum,
        st_bad_op
    } frame_status_e;

    typedef struct packed {
        frame_status_e status;
        logic [7:0]    opcode;     // raw byte, may be unknown
        logic [7:0]    seq;
        logic [63:0]   payload;
    } frame_result_t;

endpackage

`default_nettype wire

//--- verilog/link_ctrl_pkg.sv
`default_nettype none

package link_ctrl_pkg;

    typedef enum logic [1:0] {
        idle,
        prime,
        work,
        last
    } read_state_e;

    typedef enum logic [2:0] {
        wait_fill,
        reading,
        check,
        offer,
        retire
    } dec_state_e;

    typedef struct packed {
        logic       req;
        logic [7:0] data;
    } byte_link_t;

endpackage

`default_nettype wire

//--- verilog/byte_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module byte_ingress (
    input  logic                      clk,
    input  logic                      rst,
    input  link_ctrl_pkg::byte_link_t byte_in,
    output logic                      ack,
    input  logic                      full,
    output logic                      push,
    output logic [7:0]                push_data
);

    logic req_wait;     // byte taken, waiting for req to drop

    // one push per req, held off while the fifo is full
    assign push      = byte_in.req && !ack && !full;
    assign push_data = byte_in.data;
    assign req_wait  = ack && byte_in.req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (push) begin
            ack <= 1'b1;
        end else if (!req_wait) begin
            ack <= 1'b0;    // sender has released req
        end
    end

endmodule

`default_nettype wire

//--- verilog/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "frame_rx_settings.svh"

module byte_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic [`BYTE_W-1:0]            push_data,
    input  logic                          pop,
    output logic [`BYTE_W-1:0]            rd_data,
    output logic                          full,
    output logic [$clog2(`FIFO_DEPTH):0]  fill
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    logic [`BYTE_W-1:0] mem [`FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign full    = (fill == (AW+1)'(`FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (fill != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;      // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // data shows up the cycle after pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/fifo_read.sv
`timescale 1ns/1ps
`default_nettype none
`include "frame_rx_settings.svh"

module fifo_read (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fs,
    output logic                    fd,
    output logic                    fifo_rxen,
    input  logic [`BYTE_W-1:0]      fifo_rxd,
    output frame_types_pkg::frame_t res
);

    import link_ctrl_pkg::*;

    localparam int CW = $clog2(`FRAME_BYTES);

    read_state_e   state;
    read_state_e   next_state;
    logic [CW-1:0] pop_cnt;
    logic [CW-1:0] wr_idx;
    logic          cap_vld;     // fifo_rxd holds a popped byte

    assign fifo_rxen = (state == work);
    assign fd        = (state == last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (fs) begin
                    next_state = prime;
                end
            end
            prime: begin
                next_state = work;
            end
            work: begin
                if (pop_cnt == CW'(`FRAME_BYTES - 1)) begin
                    next_state = last;
                end
            end
            last: begin
                if (!fs) begin
                    next_state = idle;  // handshake closed
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pop_cnt <= '0;
            cap_vld <= 1'b0;
            wr_idx  <= '0;
        end else begin
            pop_cnt <= (state == work) ? pop_cnt + 1'b1 : '0;
            cap_vld <= fifo_rxen;
            if (state == prime) begin
                wr_idx <= '0;
            end else if (cap_vld) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // bytes land in arrival order, first one at the top
    always_ff @(posedge clk) begin
        if (cap_vld) begin
            res[wr_idx*`BYTE_W +: `BYTE_W] <= fifo_rxd;
        end
    end

endmodule

`default_nettype wire

//--- verilog/frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "frame_rx_settings.svh"

module frame_decoder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [$clog2(`FIFO_DEPTH):0]   fill,
    output logic                           fs,
    input  logic                           fd,
    input  frame_types_pkg::frame_t        frame,
    output frame_types_pkg::frame_result_t result,
    output logic                           res_req,
    input  logic                           res_ack
);

    import frame_types_pkg::*;
    import link_ctrl_pkg::*;

    localparam int SEQ_POS = `FRAME_BYTES - 2;
    localparam int SUM_POS = `FRAME_BYTES - 1;

    dec_state_e         state;
    dec_state_e         next_state;
    logic [`BYTE_W-1:0] sum;
    logic [`BYTE_W-1:0] op_byte;
    frame_status_e      status;

    assign fs      = (state == reading);
    assign res_req = (state == offer);
    assign op_byte = frame[`BYTE_W +: `BYTE_W];

    always_comb begin
        sum = '0;
        for (int i = 0; i < SUM_POS; i++) begin
            sum ^= frame[i*`BYTE_W +: `BYTE_W];
        end
    end

    // sync wins over checksum, checksum over opcode
    always_comb begin
        if (frame[0 +: `BYTE_W] != `SYNC_BYTE) begin
            status = st_bad_sync;
        end else if (sum != frame[SUM_POS*`BYTE_W +: `BYTE_W]) begin
            status = st_bad_sum;
        end else begin
            case (op_byte)
                op_write, op_read, op_ping: status = st_ok;
                default:                    status = st_bad_op;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= wait_fill;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            wait_fill: if (fill >= `FRAME_BYTES) next_state = reading;
            reading:   if (fd) next_state = check;
            check:     next_state = offer;
            offer:     if (res_ack) next_state = retire;
            retire:    if (!res_ack) next_state = wait_fill;
            default:   next_state = wait_fill;
        endcase
    end

    // held from here until res_ack falls
    always_ff @(posedge clk) begin
        if (state == check) begin
            result.status  <= status;
            result.opcode  <= op_byte;
            result.seq     <= frame[SEQ_POS*`BYTE_W +: `BYTE_W];
            result.payload <= frame[2*`BYTE_W +: 64];
        end
    end

endmodule

`default_nettype wire

//--- verilog/frame_rx_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "frame_rx_settings.svh"

module frame_rx_top (
    input  logic                           clk,
    input  logic                           rst,
    input  link_ctrl_pkg::byte_link_t      byte_in,
    output logic                           ack,
    output frame_types_pkg::frame_result_t result,
    output logic                           res_req,
    input  logic                           res_ack
);

    import frame_types_pkg::*;

    logic                          push;
    logic [`BYTE_W-1:0]            push_data;
    logic                          full;
    logic [$clog2(`FIFO_DEPTH):0]  fill;
    logic                          fifo_rxen;
    logic [`BYTE_W-1:0]            fifo_rxd;
    logic                          fs;
    logic                          fd;
    frame_t                        frame;

    byte_ingress i_byte_ingress (
        .clk       (clk),
        .rst       (rst),
        .byte_in   (byte_in),
        .ack       (ack),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    byte_fifo i_byte_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (fifo_rxen),
        .rd_data   (fifo_rxd),
        .full      (full),
        .fill      (fill)
    );

    fifo_read i_fifo_read (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fd        (fd),
        .fifo_rxen (fifo_rxen),
        .fifo_rxd  (fifo_rxd),
        .res       (frame)
    );

    frame_decoder i_frame_decoder (
        .clk       (clk),
        .rst       (rst),
        .fill      (fill),
        .fs        (fs),
        .fd        (fd),
        .frame     (frame),
        .result    (result),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;     // 40 ns period

endmodule

`default_nettype wire

//--- sim/tb_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "frame_rx_settings.svh"

module tb_frame_rx;

    import frame_types_pkg::*;
    import link_ctrl_pkg::*;

    localparam int MAX_CASES = 64;

    logic          clk;
    logic          rst;
    byte_link_t    byte_in;
    logic          ack;
    frame_result_t result;
    logic          res_req;
    logic          res_ack;

    string         case_name    [MAX_CASES];
    logic [7:0]    case_bytes   [MAX_CASES][`FRAME_BYTES];
    frame_status_e case_status  [MAX_CASES];
    logic [7:0]    case_op      [MAX_CASES];
    logic [63:0]   case_payload [MAX_CASES];
    int            case_hold    [MAX_CASES];
    int            n_cases;
    int            expect_q[$];     // case index per fully sent frame
    int            n_results;
    int            n_offers;
    logic          req_prev;
    int            value_errors;
    int            other_errors;
    int            stall_run;
    logic          stall_seen;
    logic          cases_loaded;
    logic [31:0]   lfsr;

    tb_clock_gen i_tb_clock_gen (
        .clk (clk)
    );

    frame_rx_top i_frame_rx_top (
        .clk     (clk),
        .rst     (rst),
        .byte_in (byte_in),
        .ack     (ack),
        .result  (result),
        .res_req (res_req),
        .res_ack (res_ack)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_cases();
        int         fd;
        int         code;
        int         c;
        int         st;
        string      tok;
        logic [7:0] b;
        logic [7:0] op;
        logic [63:0] pl;
        int         hold;
        fd = $fopen("sim/frame_rx_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file sim/frame_rx_cases.txt");
            other_errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                do begin
                    c = $fgetc(fd);
                end while (c != 10 && c != -1);     // skip the comment line
            end else if (n_cases < MAX_CASES) begin
                case_name[n_cases] = tok;
                for (int i = 0; i < `FRAME_BYTES; i++) begin
                    code = $fscanf(fd, "%h", b);
                    case_bytes[n_cases][i] = b;
                end
                code = $fscanf(fd, "%d %h %h %d", st, op, pl, hold);
                if (code != 4) begin
                    $display("cases file line for %s is malformed", tok);
                    other_errors++;
                end
                case_status[n_cases]  = frame_status_e'(st[1:0]);
                case_op[n_cases]      = op;
                case_payload[n_cases] = pl;
                case_hold[n_cases]    = hold;
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic report_value(input string test, input string field,
                                input logic [63:0] exp_val, input logic [63:0] got_val);
        $display("** Error %s: %s expected %0h, got %0h", test, field, exp_val, got_val);
        value_errors++;
    endtask

    task automatic check_result(input int idx);
        string name;
        name = case_name[idx];
        assert (result.status == case_status[idx])
            else report_value(name, "status", 64'(case_status[idx]), 64'(result.status));
        assert (result.opcode == case_op[idx])
            else report_value(name, "opcode", 64'(case_op[idx]), 64'(result.opcode));
        // sequence byte sits just before the checksum
        assert (result.seq == case_bytes[idx][`FRAME_BYTES-2])
            else report_value(name, "seq", 64'(case_bytes[idx][`FRAME_BYTES-2]),
                              64'(result.seq));
        assert (result.payload == case_payload[idx])
            else report_value(name, "payload", case_payload[idx], result.payload);
    endtask

    task automatic send_frames();
        int gap;
        for (int c = 0; c < n_cases; c++) begin
            for (int i = 0; i < `FRAME_BYTES; i++) begin
                @(posedge clk);
                byte_in.data <= case_bytes[c][i];
                byte_in.req  <= 1'b1;
                do begin
                    @(negedge clk);
                end while (!ack);
                if (i == `FRAME_BYTES - 1) begin
                    expect_q.push_back(c);      // whole frame is in
                end
                @(posedge clk);
                byte_in.req <= 1'b0;
                draw_bits(2, gap);
                do begin
                    @(negedge clk);
                end while (ack);
                repeat (gap) @(posedge clk);
            end
        end
    endtask

    task automatic take_results();
        int idx;
        int delay;
        while (n_results < n_cases) begin
            do begin
                @(negedge clk);
            end while (!res_req);
            delay = 0;
            if (expect_q.size() == 0) begin
                $display("a result was offered before a whole frame was sent");
                other_errors++;
            end else begin
                idx = expect_q.pop_front();
                check_result(idx);
                if (case_hold[idx] > 0) begin
                    delay = case_hold[idx];     // long back-pressure
                end else begin
                    draw_bits(4, delay);
                end
            end
            n_results++;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            res_ack <= 1'b1;
            do begin
                @(negedge clk);
            end while (res_req);
            @(posedge clk);
            res_ack <= 1'b0;
        end
    endtask

    // a long req without ack means the fifo is full
    always @(negedge clk) begin
        if (byte_in.req && !ack) begin
            stall_run = stall_run + 1;
            if (stall_run > 16) begin
                stall_seen = 1'b1;
            end
        end else begin
            stall_run = 0;
        end
    end

    // every rising res_req is one offered result
    always @(negedge clk) begin
        if (res_req && !req_prev) begin
            n_offers = n_offers + 1;
        end
        req_prev = res_req;
    end

    initial begin
        logic extra;
        logic held;
        rst          <= 1'b1;
        byte_in      <= '0;
        res_ack      <= 1'b0;
        n_cases      = 0;
        n_results    = 0;
        n_offers     = 0;
        req_prev     = 1'b0;
        value_errors = 0;
        other_errors = 0;
        stall_run    = 0;
        stall_seen   = 1'b0;
        extra        = 1'b0;
        held         = 1'b0;
        lfsr         = 32'hf49943e5;
        load_cases();
        cases_loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!res_req && !ack) else begin
            $display("res_req or ack is high right after reset");
            other_errors++;
        end
        if (n_cases == 0) begin
            $display("no test cases were loaded");
            other_errors++;
        end else begin
            fork
                send_frames();
                take_results();
            join
        end
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            if (res_req) begin
                extra = 1'b1;
            end
        end
        assert (!extra) else begin
            $display("a result was offered after all frames were answered");
            other_errors++;
        end
        assert (expect_q.size() == 0 && n_offers == n_cases) else begin
            $display("%0d frames sent but %0d results offered", n_cases, n_offers);
            other_errors++;
        end
        for (int i = 0; i < n_cases; i++) begin
            if (case_hold[i] > 0) begin
                held = 1'b1;
            end
        end
        assert (!held || stall_seen) else begin
            $display("byte ack never stalled while a result was held");
            other_errors++;
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (cases_loaded);
        limit = n_cases * (`FRAME_BYTES * 12 + 40) + 10;   // small margin for reset
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- frame_rx.f
+incdir+verilog
verilog/frame_types_pkg.sv
verilog/link_ctrl_pkg.sv
verilog/byte_ingress.sv
verilog/byte_fifo.sv
verilog/fifo_read.sv
verilog/frame_decoder.sv
verilog/frame_rx_top.sv
sim/tb_clock_gen.sv
sim/tb_frame_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_frame_rx \
    -f frame_rx.f -Mdir obj_dir \
    && ./obj_dir/Vtb_frame_rx | tee sim.log

grep -q "^STATUS: PASS$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/frame_rx_cases.txt
# name, frame bytes 0..11 (hex), status (0 ok 1 bad_sync 2 bad_sum 3 bad_op),
# opcode (hex), payload (hex), res_ack hold in cycles (0 gives a random delay)
write_ok          A5 01 11 22 33 44 55 66 77 88 00 2C 0 01 1122334455667788 0
read_ok           A5 02 DE AD BE EF 01 23 45 67 01 84 0 02 DEADBEEF01234567 0
ping_ok           A5 03 00 00 00 00 00 00 00 00 02 A4 0 03 0000000000000000 0
bad_sum           A5 01 01 02 03 04 05 06 07 08 03 FF 2 01 0102030405060708 0
after_bad_sum     A5 02 F0 E1 D2 C3 B4 A5 96 87 04 A3 0 02 F0E1D2C3B4A59687 0
bad_sync          5A 01 00 00 00 00 00 00 00 00 05 5E 1 01 0000000000000000 0
bad_sync_bad_sum  00 03 FF FF FF FF FF FF FF FF 06 00 1 03 FFFFFFFFFFFFFFFF 0
bad_op            A5 7E 10 20 30 40 50 60 70 80 07 5C 3 7E 1020304050607080 0
bad_op_zero       A5 00 00 00 00 00 00 00 00 00 08 AD 3 00 0000000000000000 0
held_ping         A5 03 01 01 01 01 01 01 01 01 09 AF 0 03 0101010101010101 400
queued_1          A5 01 00 00 00 00 00 00 00 01 0A AF 0 01 0000000000000001 0
queued_2          A5 02 00 00 00 00 00 00 00 02 0B AE 0 02 0000000000000002 0
queued_3          A5 03 00 00 00 00 00 00 00 03 0C A9 0 03 0000000000000003 0
queued_bad_sum    A5 01 00 00 00 00 00 00 00 04 0D 00 2 01 0000000000000004 0
queued_5          A5 02 12 34 56 78 9A BC DE F0 0E A9 0 02 123456789ABCDEF0 0
